// File: hw/adc_deserializer.sv
// ADC deserializer collecting four TDM slots into a frame with a valid strobe.
`timescale 1ns/1ps

module adc_deserializer #(
    parameter int W = 16
) (
    input  logic             clk_12mhz_i,
    input  logic             rst_i,
    input  logic             sdout_i,
    input  logic             bit_edge_i,
    input  logic [5:0]       bit_pos_i,
    sample_frame_if.producer adc_frame_o
);

    localparam int NS = codec_pkg::NUM_SLOTS;
    localparam int SB = codec_pkg::SLOT_BITS;
    localparam int SLOT_IDX_W = $clog2(NS);

    logic [W-1:0]          shift_q;
    logic [W-1:0]          word;
    // Slots before the last one wait here until the frame is complete.
    logic [W-1:0]          slot_q [NS-1];
    logic [SLOT_IDX_W-1:0] slot;
    logic                  slot_end;
    logic                  frame_end;
    logic signed [W-1:0]   sample_q [NS];
    logic                  valid_q;

    // The word including the bit sampled on this edge.
    assign word = {shift_q[W-2:0], sdout_i};
    assign slot = SLOT_IDX_W'(bit_pos_i / 6'(SB));
    assign slot_end = bit_edge_i && ((bit_pos_i % 6'(SB)) == 6'(SB - 1));
    assign frame_end = bit_edge_i && (bit_pos_i == 6'(codec_pkg::FRAME_BITS - 1));

    // Shifting and slot staging need no reset since a full frame overwrites them.
    always_ff @(posedge clk_12mhz_i) begin
        if (bit_edge_i) begin
            shift_q <= word;
        end
        if (slot_end && !frame_end) begin
            slot_q[slot] <= word;
        end
    end

    // The published frame changes only together with the valid pulse, so the
    // consumer sees all four samples from one frame.
    always_ff @(posedge clk_12mhz_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            for (int i = 0; i < NS; i++) begin
                sample_q[i] <= '0;
            end
        end else begin
            valid_q <= frame_end;
            if (frame_end) begin
                for (int i = 0; i < NS - 1; i++) begin
                    sample_q[i] <= slot_q[i];
                end
                sample_q[NS-1] <= word;
            end
        end
    end

    assign adc_frame_o.valid   = valid_q;
    assign adc_frame_o.sample0 = sample_q[0];
    assign adc_frame_o.sample1 = sample_q[1];
    assign adc_frame_o.sample2 = sample_q[2];
    assign adc_frame_o.sample3 = sample_q[3];

endmodule

// File: hw/cal_pkg.sv
// Calibration package with per-channel offset and gain tables and the calibrator state.
package cal_pkg;

    // One calibration entry per codec channel.
    localparam int NUM_CH = codec_pkg::NUM_SLOTS;

    // Gains are signed Q2.14, so 16384 is unity and the range is just under +/-2.
    localparam int GAIN_FRAC_BITS = 14;
    localparam int GAIN_W = 16;
    localparam int OFFSET_W = 16;

    // ADC offsets are removed before the gain is applied.
    localparam logic signed [OFFSET_W-1:0] ADC_OFFSET [NUM_CH] =
        '{16'sd120, -16'sd340, 16'sd25, -16'sd60};

    // Channels 0 and 2 have gain above unity, so near full scale they clip.
    localparam logic signed [GAIN_W-1:0] ADC_GAIN [NUM_CH] =
        '{16'sd17203, 16'sd16002, 16'sd18022, 16'sd15565};

    // DAC gains are applied first; the offset is added to the scaled code.
    localparam logic signed [GAIN_W-1:0] DAC_GAIN [NUM_CH] =
        '{16'sd16712, 16'sd15892, 16'sd17530, 16'sd16384};

    localparam logic signed [OFFSET_W-1:0] DAC_OFFSET [NUM_CH] =
        '{-16'sd210, 16'sd95, 16'sd40, -16'sd15};

    // Calibrator sequence: wait for a frame, four ADC channels, four DAC channels.
    typedef enum logic [1:0] {CAL_IDLE, CAL_ADC, CAL_DAC} cal_state_e;

endpackage

// File: hw/codec_frontend_top.sv
// Codec front end top level joining the TDM link blocks to the codec pins and DSP ports.
`timescale 1ns/1ps

module codec_frontend_top #(
    parameter int W = 16
) (
    input  logic                clk_12mhz_i,
    input  logic                rst_i,
    input  logic                sdout_i,
    output logic                bick_o,
    output logic                lrck_o,
    output logic                sdin_o,
    output logic                pdn_o,
    input  logic signed [W-1:0] cal_out0_i,
    input  logic signed [W-1:0] cal_out1_i,
    input  logic signed [W-1:0] cal_out2_i,
    input  logic signed [W-1:0] cal_out3_i,
    input  logic signed [W-1:0] force_dac_output_i,
    output logic signed [W-1:0] cal_in0_o,
    output logic signed [W-1:0] cal_in1_o,
    output logic signed [W-1:0] cal_in2_o,
    output logic signed [W-1:0] cal_in3_o,
    output logic                sample_clk_o
);

    logic [5:0] bit_pos;
    logic       bit_edge;

    // Raw frames from the codec and calibrated frames back to it.
    sample_frame_if #(.W(W)) adc_frame ();
    sample_frame_if #(.W(W)) dac_frame ();

    // Keep the codec powered down while the design is in reset.
    always_ff @(posedge clk_12mhz_i) begin
        if (rst_i) begin
            pdn_o <= 1'b0;
        end else begin
            pdn_o <= 1'b1;
        end
    end

    tdm_clock_gen u_clock_gen (
        .clk_12mhz_i (clk_12mhz_i),
        .rst_i       (rst_i),
        .bick_o      (bick_o),
        .lrck_o      (lrck_o),
        .bit_pos_o   (bit_pos),
        .bit_edge_o  (bit_edge)
    );

    adc_deserializer #(.W(W)) u_adc_deser (
        .clk_12mhz_i (clk_12mhz_i),
        .rst_i       (rst_i),
        .sdout_i     (sdout_i),
        .bit_edge_i  (bit_edge),
        .bit_pos_i   (bit_pos),
        .adc_frame_o (adc_frame.producer)
    );

    sample_calibrator #(.W(W)) u_calibrator (
        .clk_12mhz_i        (clk_12mhz_i),
        .rst_i              (rst_i),
        .adc_frame_i        (adc_frame.consumer),
        .dac_frame_o        (dac_frame.producer),
        .cal_out0_i         (cal_out0_i),
        .cal_out1_i         (cal_out1_i),
        .cal_out2_i         (cal_out2_i),
        .cal_out3_i         (cal_out3_i),
        .force_dac_output_i (force_dac_output_i),
        .cal_in0_o          (cal_in0_o),
        .cal_in1_o          (cal_in1_o),
        .cal_in2_o          (cal_in2_o),
        .cal_in3_o          (cal_in3_o),
        .sample_clk_o       (sample_clk_o)
    );

    dac_serializer #(.W(W)) u_dac_ser (
        .clk_12mhz_i (clk_12mhz_i),
        .rst_i       (rst_i),
        .bit_edge_i  (bit_edge),
        .bit_pos_i   (bit_pos),
        .dac_frame_i (dac_frame.consumer),
        .sdin_o      (sdin_o)
    );

endmodule

// File: hw/codec_pkg.sv
// Codec link package with the TDM frame format shared by the link blocks.
package codec_pkg;

    // Four TDM slots per frame, one per codec channel.
    localparam int NUM_SLOTS = 4;

    // Each bit lasts this many system clock cycles.
    // The bit clock is low in the first half of a bit and high in the second.
    localparam int CLKS_PER_BIT = 2;

    // Slot width in bits, sent MSB first.
    localparam int SLOT_BITS = 16;

    // Bits in one frame across all slots.
    localparam int FRAME_BITS = NUM_SLOTS * SLOT_BITS;

    // One full frame in system clock cycles.
    // This is also the period of the frame sync.
    localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;

endpackage

// File: hw/dac_serializer.sv
// DAC serializer shifting a calibrated four-slot frame out MSB first.
`timescale 1ns/1ps

module dac_serializer #(
    parameter int W = 16
) (
    input  logic             clk_12mhz_i,
    input  logic             rst_i,
    input  logic             bit_edge_i,
    input  logic [5:0]       bit_pos_i,
    sample_frame_if.consumer dac_frame_i,
    output logic             sdin_o
);

    localparam int FW = codec_pkg::NUM_SLOTS * W;

    // The newest frame from the calibrator waits here for a frame boundary.
    logic [FW-1:0] pending_q;
    logic [FW-1:0] shift_q;
    logic          last_bit;

    // The edge of bit 63 is the last chance to set up bit 0 of the next frame.
    assign last_bit = bit_edge_i && (bit_pos_i == 6'(codec_pkg::FRAME_BITS - 1));

    // The output flop updates at the end of the high bick cycle, so the new
    // bit appears exactly when bick falls and holds through the next rise.
    always_ff @(posedge clk_12mhz_i) begin
        if (rst_i) begin
            pending_q <= '0;
            shift_q   <= '0;
            sdin_o    <= 1'b0;
        end else begin
            if (dac_frame_i.valid) begin
                pending_q <= {dac_frame_i.sample0, dac_frame_i.sample1,
                              dac_frame_i.sample2, dac_frame_i.sample3};
            end
            if (last_bit) begin
                // Start the new frame with the MSB of slot 0.
                shift_q <= pending_q;
                sdin_o  <= pending_q[FW-1];
            end else if (bit_edge_i) begin
                shift_q <= {shift_q[FW-2:0], 1'b0};
                sdin_o  <= shift_q[FW-2];
            end
        end
    end

endmodule

// File: hw/sample_calibrator.sv
// Sample calibrator applying offset and gain to ADC and DAC frames with one multiplier.
`timescale 1ns/1ps

module sample_calibrator #(
    parameter int W = 16
) (
    input  logic                clk_12mhz_i,
    input  logic                rst_i,
    sample_frame_if.consumer    adc_frame_i,
    sample_frame_if.producer    dac_frame_o,
    input  logic signed [W-1:0] cal_out0_i,
    input  logic signed [W-1:0] cal_out1_i,
    input  logic signed [W-1:0] cal_out2_i,
    input  logic signed [W-1:0] cal_out3_i,
    input  logic signed [W-1:0] force_dac_output_i,
    output logic signed [W-1:0] cal_in0_o,
    output logic signed [W-1:0] cal_in1_o,
    output logic signed [W-1:0] cal_in2_o,
    output logic signed [W-1:0] cal_in3_o,
    output logic                sample_clk_o
);

    localparam int NCH = cal_pkg::NUM_CH;
    localparam int CH_W = $clog2(NCH);
    localparam int GW = cal_pkg::GAIN_W;
    // Product width: W+1 bit operand times a GW bit gain.
    localparam int PW = W + 1 + GW;
    localparam logic signed [W-1:0] S_MAX = {1'b0, {(W-1){1'b1}}};
    localparam logic signed [W-1:0] S_MIN = {1'b1, {(W-1){1'b0}}};

    cal_pkg::cal_state_e state;
    logic [CH_W-1:0]     ch;
    logic signed [W-1:0] adc_raw [NCH];
    logic signed [W-1:0] dsp_out [NCH];
    logic signed [W-1:0] out_q [NCH];
    logic signed [W-1:0] force_q;
    // Channels before the last one wait here; the last result goes straight out.
    logic signed [W-1:0] adc_res [NCH-1];
    logic signed [W-1:0] dac_res [NCH-1];
    logic signed [W-1:0] cal_in_q [NCH];
    logic signed [W-1:0] dac_q [NCH];
    logic                dac_valid;
    logic                last_ch;
    logic signed [W-1:0] dac_src;
    logic signed [W-1:0] force_val;
    logic signed [W:0]   mul_a;
    logic signed [GW-1:0] mul_b;
    logic signed [PW:0]  add_c;
    logic signed [PW-1:0] product;
    logic signed [PW:0]  sum;
    logic signed [W-1:0] result;

    assign adc_raw[0] = adc_frame_i.sample0;
    assign adc_raw[1] = adc_frame_i.sample1;
    assign adc_raw[2] = adc_frame_i.sample2;
    assign adc_raw[3] = adc_frame_i.sample3;
    assign dsp_out[0] = cal_out0_i;
    assign dsp_out[1] = cal_out1_i;
    assign dsp_out[2] = cal_out2_i;
    assign dsp_out[3] = cal_out3_i;

    assign last_ch = (ch == CH_W'(NCH - 1));

    // DAC channel 0 runs in the capture cycle itself, so it reads the ports
    // directly while the later channels read the captured copies.
    always_comb begin
        dac_src   = (ch == '0) ? dsp_out[0] : out_q[ch];
        force_val = (ch == '0) ? force_dac_output_i : force_q;
        if (state == cal_pkg::CAL_DAC) begin
            mul_a = (W+1)'(dac_src);
            mul_b = cal_pkg::DAC_GAIN[ch];
            add_c = (PW+1)'(cal_pkg::DAC_OFFSET[ch]);
        end else begin
            // ADC offset is removed before scaling, one extra bit avoids wrap.
            mul_a = (W+1)'(adc_raw[ch]) - (W+1)'(cal_pkg::ADC_OFFSET[ch]);
            mul_b = cal_pkg::ADC_GAIN[ch];
            add_c = '0;
        end
        product = mul_a * mul_b;
        sum     = (PW+1)'(product >>> cal_pkg::GAIN_FRAC_BITS) + add_c;
        // Clamp to the signed sample range.
        if (sum > (PW+1)'(S_MAX)) begin
            result = S_MAX;
        end else if (sum < (PW+1)'(S_MIN)) begin
            result = S_MIN;
        end else begin
            result = W'(sum);
        end
        // A nonzero force code bypasses DAC calibration entirely.
        if (state == cal_pkg::CAL_DAC && force_val != '0) begin
            result = force_val;
        end
    end

    // Per-channel results and the captured DSP outputs.
    always_ff @(posedge clk_12mhz_i) begin
        if (state == cal_pkg::CAL_ADC && !last_ch) begin
            adc_res[ch] <= result;
        end
        if (state == cal_pkg::CAL_DAC && !last_ch) begin
            dac_res[ch] <= result;
        end
        if (sample_clk_o) begin
            out_q   <= dsp_out;
            force_q <= force_dac_output_i;
        end
    end

    // Sequence control. The held frames update all at once on the last channel.
    always_ff @(posedge clk_12mhz_i) begin
        if (rst_i) begin
            state        <= cal_pkg::CAL_IDLE;
            ch           <= '0;
            sample_clk_o <= 1'b0;
            dac_valid    <= 1'b0;
            for (int i = 0; i < NCH; i++) begin
                cal_in_q[i] <= '0;
                dac_q[i]    <= '0;
            end
        end else begin
            sample_clk_o <= 1'b0;
            dac_valid    <= 1'b0;
            case (state)
                cal_pkg::CAL_IDLE: begin
                    ch <= '0;
                    if (adc_frame_i.valid) begin
                        state <= cal_pkg::CAL_ADC;
                    end
                end
                cal_pkg::CAL_ADC: begin
                    ch <= ch + 1'b1;
                    if (last_ch) begin
                        for (int i = 0; i < NCH - 1; i++) begin
                            cal_in_q[i] <= adc_res[i];
                        end
                        cal_in_q[NCH-1] <= result;
                        // The DSP core takes its new inputs and gives its outputs here.
                        sample_clk_o    <= 1'b1;
                        state           <= cal_pkg::CAL_DAC;
                    end
                end
                cal_pkg::CAL_DAC: begin
                    ch <= ch + 1'b1;
                    if (last_ch) begin
                        for (int i = 0; i < NCH - 1; i++) begin
                            dac_q[i] <= dac_res[i];
                        end
                        dac_q[NCH-1] <= result;
                        dac_valid    <= 1'b1;
                        state        <= cal_pkg::CAL_IDLE;
                    end
                end
                default: state <= cal_pkg::CAL_IDLE;
            endcase
        end
    end

    assign cal_in0_o = cal_in_q[0];
    assign cal_in1_o = cal_in_q[1];
    assign cal_in2_o = cal_in_q[2];
    assign cal_in3_o = cal_in_q[3];

    assign dac_frame_o.valid   = dac_valid;
    assign dac_frame_o.sample0 = dac_q[0];
    assign dac_frame_o.sample1 = dac_q[1];
    assign dac_frame_o.sample2 = dac_q[2];
    assign dac_frame_o.sample3 = dac_q[3];

endmodule

// File: hw/sample_frame_if.sv
// Frame interface carrying four channel samples and a one-cycle valid strobe.
`timescale 1ns/1ps

interface sample_frame_if #(
    parameter int W = 16
) ();

    // Valid pulses for one cycle when a new frame is presented.
    // The samples then hold their value until the next pulse.
    logic                valid;
    logic signed [W-1:0] sample0;
    logic signed [W-1:0] sample1;
    logic signed [W-1:0] sample2;
    logic signed [W-1:0] sample3;

    // There is no back-pressure, so the receiver only has inputs.
    modport producer (output valid, sample0, sample1, sample2, sample3);
    modport consumer (input  valid, sample0, sample1, sample2, sample3);

endinterface

// File: hw/tdm_clock_gen.sv
// TDM clock generator producing bit clock, frame sync and the current bit index.
`timescale 1ns/1ps

module tdm_clock_gen (
    input  logic       clk_12mhz_i,
    input  logic       rst_i,
    output logic       bick_o,
    output logic       lrck_o,
    output logic [5:0] bit_pos_o,
    output logic       bit_edge_o
);

    localparam int CNT_W = $clog2(codec_pkg::FRAME_CLKS);
    localparam int CPB = codec_pkg::CLKS_PER_BIT;

    // Position inside the frame in system clock cycles.
    logic [CNT_W-1:0] cnt_q;
    // Position inside the current bit.
    logic [CNT_W-1:0] phase;
    logic             high_phase;

    assign phase = cnt_q % CNT_W'(CPB);
    // The bit clock is high during the second half of each bit.
    assign high_phase = (phase >= CNT_W'(CPB / 2));

    // Outputs lag the counter by one cycle so that every pin comes straight
    // from a flop. After reset everything is low and the first frame starts
    // one cycle later.
    always_ff @(posedge clk_12mhz_i) begin
        if (rst_i) begin
            cnt_q      <= '0;
            bick_o     <= 1'b0;
            lrck_o     <= 1'b0;
            bit_pos_o  <= '0;
            bit_edge_o <= 1'b0;
        end else begin
            if (cnt_q == CNT_W'(codec_pkg::FRAME_CLKS - 1)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            bick_o     <= high_phase;
            // The edge strobe marks the first high cycle, where data is sampled.
            bit_edge_o <= (phase == CNT_W'(CPB / 2));
            bit_pos_o  <= 6'(cnt_q / CNT_W'(CPB));
            // Frame sync covers bit 0 only.
            lrck_o     <= (cnt_q < CNT_W'(CPB));
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module codec_frontend_tb \
    -f sources.f -o sim_codec_frontend || exit 1
out=$(./obj_dir/sim_codec_frontend)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// File: sources.f
hw/codec_pkg.sv
hw/cal_pkg.sv
hw/sample_frame_if.sv
hw/tdm_clock_gen.sv
hw/adc_deserializer.sv
hw/sample_calibrator.sv
hw/dac_serializer.sv
hw/codec_frontend_top.sv
verification/tb_clock_gen.sv
verification/codec_frontend_sva.sv
verification/codec_frontend_tb.sv

// File: verification/codec_frontend_sva.sv
// Codec front end assertions on frame sync period, data stability and strobes.
`timescale 1ns/1ps

module codec_frontend_sva (
    input logic clk_i,
    input logic rst_i,
    input logic bick_i,
    input logic lrck_i,
    input logic sdin_i,
    input logic pdn_i,
    input logic sample_clk_i
);

    localparam int GAP_W = 8;

    logic             lrck_d;
    logic             seen_q;
    logic [GAP_W-1:0] gap_q;
    logic             lrck_rise;

    assign lrck_rise = lrck_i && !lrck_d;

    // Cycles since the last frame sync rise, saturating at the top.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lrck_d <= 1'b0;
            seen_q <= 1'b0;
            gap_q  <= '0;
        end else begin
            lrck_d <= lrck_i;
            if (lrck_rise) begin
                gap_q  <= GAP_W'(1);
                seen_q <= 1'b1;
            end else if (gap_q != '1) begin
                gap_q <= gap_q + 1'b1;
            end
        end
    end

    sample_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
        sample_clk_i |=> !sample_clk_i)
        else $error("sample_clk_o stayed high for more than one cycle");

    // Every rise after the first one comes exactly one frame later.
    lrck_period_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (lrck_rise && seen_q) |-> (gap_q == GAP_W'(codec_pkg::FRAME_CLKS)))
        else $error("lrck_o rise is not one frame after the previous rise");

    // The codec samples on rising bick, so data must hold through the high phase.
    sdin_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        bick_i |-> $stable(sdin_i))
        else $error("sdin_o changed while bick_o was high");

    pdn_reset_a: assert property (@(posedge clk_i)
        rst_i |=> !pdn_i)
        else $error("pdn_o was high during reset");

endmodule

bind codec_frontend_top codec_frontend_sva u_sva (
    .clk_i        (clk_12mhz_i),
    .rst_i        (rst_i),
    .bick_i       (bick_o),
    .lrck_i       (lrck_o),
    .sdin_i       (sdin_o),
    .pdn_i        (pdn_o),
    .sample_clk_i (sample_clk_o)
);

// File: verification/codec_frontend_tb.sv
// Codec front end testbench with a TDM codec model and a calibration reference model.
`timescale 1ns/1ps

module codec_frontend_tb;

    localparam int W = 16;
    localparam int NS = codec_pkg::NUM_SLOTS;
    localparam int FB = codec_pkg::FRAME_BITS;
    // Eight table frames followed by four LFSR frames.
    localparam int NT = 8;
    localparam int NR = 4;
    localparam int NF = NT + NR;
    // The first two DAC frames carry the reset contents of the serializer.
    localparam int DAC_FRAMES = NF + 2;
    localparam int TIMEOUT = (NF + 2) * codec_pkg::FRAME_CLKS + 200;

    logic                clk;
    logic                rst;
    logic                sdout;
    logic                bick;
    logic                lrck;
    logic                sdin;
    logic                pdn;
    logic                sample_clk;
    logic signed [W-1:0] cal_out [NS];
    logic signed [W-1:0] cal_in [NS];
    logic signed [W-1:0] force_val;

    // Stimulus per frame: raw ADC samples, DSP outputs and the force code.
    logic signed [W-1:0] raw_tab [NF][NS];
    logic signed [W-1:0] out_tab [NF][NS];
    logic signed [W-1:0] force_tab [NF];

    logic [15:0] lfsr;
    logic [FB-1:0] rx_word;
    logic        lrck_prev;
    int          errors;
    int          checks;
    int          dac_checked;
    int          bit_cnt;
    int          link_frame;
    int          since_rise;
    int          high_len;
    int          rises;
    int          cycles = 0;

    tb_clock_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    codec_frontend_top #(.W(W)) dut (
        .clk_12mhz_i        (clk),
        .rst_i              (rst),
        .sdout_i            (sdout),
        .bick_o             (bick),
        .lrck_o             (lrck),
        .sdin_o             (sdin),
        .pdn_o              (pdn),
        .cal_out0_i         (cal_out[0]),
        .cal_out1_i         (cal_out[1]),
        .cal_out2_i         (cal_out[2]),
        .cal_out3_i         (cal_out[3]),
        .force_dac_output_i (force_val),
        .cal_in0_o          (cal_in[0]),
        .cal_in1_o          (cal_in[1]),
        .cal_in2_o          (cal_in[2]),
        .cal_in3_o          (cal_in[3]),
        .sample_clk_o       (sample_clk)
    );

    task automatic check_value(string name, longint got, longint exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Clamp to the signed W-bit range.
    function automatic logic signed [W-1:0] saturate(longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (W - 1)) - 1;
        lo = -(longint'(1) <<< (W - 1));
        if (v > hi) begin
            return W'(hi);
        end
        if (v < lo) begin
            return W'(lo);
        end
        return W'(v);
    endfunction

    // Input calibration: remove offset, scale by the Q2.14 gain, clamp.
    function automatic logic signed [W-1:0] adc_expect(int ch, logic signed [W-1:0] raw);
        longint prod;
        prod = (longint'(raw) - longint'(cal_pkg::ADC_OFFSET[ch]))
             * longint'(cal_pkg::ADC_GAIN[ch]);
        return saturate(prod >>> cal_pkg::GAIN_FRAC_BITS);
    endfunction

    // Output calibration: scale, then add offset, clamp. A force code wins.
    function automatic logic signed [W-1:0] dac_expect(int ch, logic signed [W-1:0] val,
                                                       logic signed [W-1:0] frc);
        longint prod;
        if (frc != '0) begin
            return frc;
        end
        prod = longint'(val) * longint'(cal_pkg::DAC_GAIN[ch]);
        return saturate((prod >>> cal_pkg::GAIN_FRAC_BITS)
                        + longint'(cal_pkg::DAC_OFFSET[ch]));
    endfunction

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit of the word.
    task automatic random_word(output logic signed [W-1:0] word);
        word = '0;
        for (int i = 0; i < W; i++) begin
            word = {word[W-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic set_row(int idx, int r0, int r1, int r2, int r3,
                           int o0, int o1, int o2, int o3, int frc);
        raw_tab[idx]   = '{W'(r0), W'(r1), W'(r2), W'(r3)};
        out_tab[idx]   = '{W'(o0), W'(o1), W'(o2), W'(o3)};
        force_tab[idx] = W'(frc);
    endtask

    task automatic build_stimulus();
        logic signed [W-1:0] word;
        set_row(0, 1000, -1000, 2500, -2500, 1000, -2000, 3000, -4000, 0);
        // Full scale both ways; channels 0 and 2 clip on gain.
        set_row(1, 32767, -32768, 32767, -32768, 32767, -32768, 32767, -32768, 0);
        set_row(2, -32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767, 0);
        // Raw values sitting on the offsets, then one step either side.
        set_row(3, 120, -340, 25, -60, 200, -100, -40, 15, 0);
        set_row(4, 119, -341, 24, -61, -1, 1, -1, 1, 0);
        set_row(5, 121, -339, 26, -59, 100, -100, 0, 0, 0);
        set_row(6, 5000, -5000, 12000, -12000, 1234, -1234, 4321, -4321, -12345);
        set_row(7, 30000, -30000, 28000, -20000, -30000, 30000, 31000, -31000, 0);
        for (int f = NT; f < NF; f++) begin
            for (int s = 0; s < NS; s++) begin
                random_word(word);
                raw_tab[f][s] = word;
                random_word(word);
                out_tab[f][s] = word;
            end
            force_tab[f] = '0;
        end
    endtask

    // ADC bit p of link frame f, slot 0 first and MSB first. Idle frames are zero.
    function automatic logic adc_bit(int f, int p);
        logic [FB-1:0] word;
        if (f >= NF) begin
            return 1'b0;
        end
        word = {raw_tab[f][0], raw_tab[f][1], raw_tab[f][2], raw_tab[f][3]};
        return word[FB-1-p];
    endfunction

    // Frame k's DSP outputs leave in link frame k+2.
    task automatic check_dac_frame(int f, logic [FB-1:0] word);
        logic signed [W-1:0] got;
        logic signed [W-1:0] exp;
        int                  k;
        k = f - 2;
        for (int s = 0; s < NS; s++) begin
            got = word[FB-1-s*W -: W];
            if (k < 0) begin
                exp = '0;
            end else begin
                exp = dac_expect(s, out_tab[k][s], force_tab[k]);
            end
            check_value($sformatf("sdin_o frame %0d slot %0d", f, s), got, exp);
        end
        dac_checked++;
    endtask

    // Codec model. Both directions act at the edge where bick falls, which ends
    // the high phase in which the DUT samples and the codec would sample.
    always @(posedge clk) begin
        if (rst) begin
            sdout      <= adc_bit(0, 0);
            bit_cnt    = 0;
            link_frame = 0;
        end else if (bick) begin
            if (lrck) begin
                check_value("bit count at frame sync", bit_cnt, 0);
            end
            rx_word = {rx_word[FB-2:0], sdin};
            if (bit_cnt == FB - 1) begin
                if (link_frame < DAC_FRAMES) begin
                    check_dac_frame(link_frame, rx_word);
                end
                link_frame = link_frame + 1;
                bit_cnt    = 0;
            end else begin
                bit_cnt = bit_cnt + 1;
            end
            sdout <= adc_bit(link_frame, bit_cnt);
        end
    end

    // Frame sync period and width as seen on the pin.
    always @(posedge clk) begin
        if (rst) begin
            lrck_prev  = 1'b0;
            since_rise = 0;
            high_len   = 0;
            rises      = 0;
        end else begin
            since_rise = since_rise + 1;
            if (lrck && !lrck_prev) begin
                if (rises > 0) begin
                    check_value("lrck_o period", since_rise, codec_pkg::FRAME_CLKS);
                end
                since_rise = 0;
                rises      = rises + 1;
            end
            if (lrck) begin
                high_len = high_len + 1;
            end else if (lrck_prev) begin
                check_value("lrck_o high cycles", high_len, codec_pkg::CLKS_PER_BIT);
                high_len = 0;
            end
            lrck_prev = lrck;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        sdout       = 1'b0;
        cal_out     = '{default: '0};
        force_val   = '0;
        rx_word     = '0;
        errors      = 0;
        checks      = 0;
        dac_checked = 0;
        lfsr        = 16'd54;
        build_stimulus();

        // First edge after release still shows the reset state.
        @(negedge rst);
        @(posedge clk);
        check_value("bick_o", bick, 0);
        check_value("lrck_o", lrck, 0);
        check_value("sdin_o", sdin, 0);
        check_value("sample_clk_o", sample_clk, 0);
        check_value("pdn_o", pdn, 0);
        for (int ch = 0; ch < NS; ch++) begin
            check_value($sformatf("cal_in%0d_o", ch), cal_in[ch], 0);
        end
        cal_out   <= out_tab[0];
        force_val <= force_tab[0];
        @(posedge clk);
        check_value("pdn_o", pdn, 1);

        // Each pulse carries frame k; the DSP outputs for it are taken at this edge.
        for (int k = 0; k < NF; k++) begin
            @(posedge clk);
            while (!sample_clk) begin
                @(posedge clk);
            end
            for (int ch = 0; ch < NS; ch++) begin
                check_value($sformatf("cal_in%0d_o frame %0d", ch, k), cal_in[ch],
                            adc_expect(ch, raw_tab[k][ch]));
            end
            if (k + 1 < NF) begin
                cal_out   <= out_tab[k+1];
                force_val <= force_tab[k+1];
            end else begin
                cal_out   <= '{default: '0};
                force_val <= '0;
            end
        end

        wait (dac_checked == DAC_FRAMES);
        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock and reset source, 8 ns clock with a synchronous reset pulse.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, so the DUT sees a clean first cycle.
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule
